/* hw/eth_tx_pkg.sv */
`default_nettype none

package eth_tx_pkg;

    // datapath widths, the lane arithmetic assumes four bytes per word
    localparam int XGMII_DATA_WIDTH  = 32;
    localparam int XGMII_CTRL_WIDTH  = 4;
    localparam int KEEP_WIDTH        = 4;
    localparam int CRC_WIDTH         = 32;
    localparam int STAT_WIDTH        = 32;
    localparam int FRAME_BYTES_WIDTH = 16;
    localparam int LANE_CNT_WIDTH    = $clog2(KEEP_WIDTH + 1);

    // on-wire byte values
    localparam logic [7:0] ETH_PREAMBLE = 8'h55;
    localparam logic [7:0] ETH_SFD      = 8'hD5;
    localparam logic [7:0] ETH_PAD      = 8'h00;
    localparam logic [7:0] XGMII_START  = 8'hFB;
    localparam logic [7:0] XGMII_TERM   = 8'hFD;
    localparam logic [7:0] XGMII_IDLE   = 8'h07;

    // 60 payload bytes before the FCS is the Ethernet minimum
    localparam int MIN_PAYLOAD_WORDS = 15;
    localparam int IFG_IDLE_WORDS    = 3;
    localparam int WORD_CNT_WIDTH    = $clog2(MIN_PAYLOAD_WORDS + 1);
    localparam int IFG_CNT_WIDTH     = $clog2(IFG_IDLE_WORDS + 1);
    localparam int FCS_BYTES         = CRC_WIDTH / 8;

    localparam logic [CRC_WIDTH-1:0] CRC_INIT = '1;
    // reflected form of the IEEE 802.3 polynomial 0x04C11DB7
    localparam logic [CRC_WIDTH-1:0] CRC_POLY = 32'hEDB88320;

    typedef enum logic [2:0] {
        IDLE,
        DATA,
        PADDING,
        FCS,
        IFG
    } tx_state_t;

    typedef struct packed {
        logic [XGMII_DATA_WIDTH-1:0] data;
        logic [XGMII_CTRL_WIDTH-1:0] ctrl;
        logic                        valid;
    } xgmii_word_t;

    typedef struct packed {
        logic [XGMII_DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0]       keep;
        logic                        last;
    } axis_word_t;

    // byte_count covers payload, padding and FCS but not the preamble
    typedef struct packed {
        logic                         strobe;
        logic [FRAME_BYTES_WIDTH-1:0] byte_count;
    } frame_done_t;

endpackage

`default_nettype wire

/* hw/crc32.sv */
`timescale 1ns/1ps
`default_nettype none

module crc32 (
    input  wire  [eth_tx_pkg::XGMII_DATA_WIDTH-1:0] i_data,
    input  wire  [eth_tx_pkg::KEEP_WIDTH-1:0]       i_byte_valid,
    input  wire  [eth_tx_pkg::CRC_WIDTH-1:0]        i_crc_state,
    output logic [eth_tx_pkg::CRC_WIDTH-1:0]        o_crc_state,
    output logic [eth_tx_pkg::CRC_WIDTH-1:0]        o_fcs
);
    import eth_tx_pkg::*;

    logic [CRC_WIDTH-1:0] crc_next;
    logic [7:0]           lane_byte;

    // bytes are folded in lowest lane first and each byte goes LSB first,
    // which is the order they leave on the wire
    always_comb begin
        crc_next  = i_crc_state;
        lane_byte = '0;
        for (int lane = 0; lane < KEEP_WIDTH; lane++) begin
            if (i_byte_valid[lane]) begin
                lane_byte = i_data[lane*8 +: 8];
                crc_next  = crc_next ^ {{(CRC_WIDTH-8){1'b0}}, lane_byte};
                for (int bit_idx = 0; bit_idx < 8; bit_idx++) begin
                    if (crc_next[0]) begin
                        crc_next = (crc_next >> 1) ^ CRC_POLY;
                    end else begin
                        crc_next = crc_next >> 1;
                    end
                end
            end
        end
    end

    // an all-zero mask leaves the state untouched, so the FCS can be
    // read out again on any later cycle until the next word arrives
    assign o_crc_state = crc_next;

    // complemented remainder, lane 0 holds the first FCS byte on the wire
    assign o_fcs = ~crc_next;

endmodule

`default_nettype wire

/* hw/tx_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_mac (
    input  wire                         i_clk,
    input  wire                         i_reset_n,
    input  wire                         i_s_axis_valid,
    input  wire eth_tx_pkg::axis_word_t i_s_axis_word,
    output logic                        o_s_axis_ready,
    input  wire                         i_xgmii_pause,
    output eth_tx_pkg::xgmii_word_t     o_xgmii,
    output eth_tx_pkg::frame_done_t     o_frame_done
);
    import eth_tx_pkg::*;

    tx_state_t                       state;
    logic [2*XGMII_DATA_WIDTH-1:0]   data_pipe;
    logic [2*XGMII_CTRL_WIDTH-1:0]   ctrl_pipe;
    logic                            adv;
    logic                            ready_q;
    logic                            xfer;
    logic [WORD_CNT_WIDTH-1:0]       word_cnt;
    logic [IFG_CNT_WIDTH-1:0]        ifg_cnt;
    logic                            term_set;
    logic [KEEP_WIDTH-1:0]           last_mask;
    logic [FRAME_BYTES_WIDTH-1:0]    byte_cnt;

    logic                            in_min_region;
    logic [XGMII_DATA_WIDTH-1:0]     decoded_data;
    logic [KEEP_WIDTH-1:0]           decoded_mask;
    logic [LANE_CNT_WIDTH-1:0]       decoded_bytes;

    logic [XGMII_DATA_WIDTH-1:0]     crc_data;
    logic [KEEP_WIDTH-1:0]           crc_mask;
    logic [CRC_WIDTH-1:0]            crc_state;
    logic [CRC_WIDTH-1:0]            crc_next;
    logic [CRC_WIDTH-1:0]            crc_fcs;

    logic [XGMII_DATA_WIDTH-1:0]     last_word;
    logic [XGMII_DATA_WIDTH-1:0]     fcs_lo;
    logic [XGMII_DATA_WIDTH-1:0]     fcs_hi;
    logic [XGMII_CTRL_WIDTH-1:0]     fcs_hi_ctrl;

    // a word moves through the pipeline on every cycle where adv is high,
    // adv is pause delayed by one and the output register adds the second
    assign xfer           = ready_q && i_s_axis_valid;
    assign o_s_axis_ready = ready_q;

    // unkept lanes become pad bytes, and inside the first 60 bytes the mask
    // is forced full so that padding of a short last word enters the CRC
    always_comb begin
        in_min_region = (word_cnt < MIN_PAYLOAD_WORDS);
        decoded_mask  = in_min_region ? {KEEP_WIDTH{1'b1}} : i_s_axis_word.keep;
        decoded_data  = {KEEP_WIDTH{ETH_PAD}};
        decoded_bytes = '0;
        for (int lane = 0; lane < KEEP_WIDTH; lane++) begin
            if (i_s_axis_word.keep[lane]) begin
                decoded_data[lane*8 +: 8] = i_s_axis_word.data[lane*8 +: 8];
            end
            if (decoded_mask[lane]) begin
                decoded_bytes = decoded_bytes + 1'b1;
            end
        end
    end

    crc32 u_crc32 (
        .i_data       (crc_data),
        .i_byte_valid (crc_mask),
        .i_crc_state  (crc_state),
        .o_crc_state  (crc_next),
        .o_fcs        (crc_fcs)
    );

    // the final payload word sits in the upper pipeline half when FCS starts,
    // the FCS fills its free lanes and the terminate follows right after
    always_comb begin
        last_word = data_pipe[2*XGMII_DATA_WIDTH-1 -: XGMII_DATA_WIDTH];
        case (last_mask)
            4'b0001: begin
                fcs_lo      = {crc_fcs[23:0], last_word[7:0]};
                fcs_hi      = {XGMII_IDLE, XGMII_IDLE, XGMII_TERM, crc_fcs[31:24]};
                fcs_hi_ctrl = 4'b1110;
            end
            4'b0011: begin
                fcs_lo      = {crc_fcs[15:0], last_word[15:0]};
                fcs_hi      = {XGMII_IDLE, XGMII_TERM, crc_fcs[31:16]};
                fcs_hi_ctrl = 4'b1100;
            end
            4'b0111: begin
                fcs_lo      = {crc_fcs[7:0], last_word[23:0]};
                fcs_hi      = {XGMII_TERM, crc_fcs[31:8]};
                fcs_hi_ctrl = 4'b1000;
            end
            default: begin
                fcs_lo      = last_word;
                fcs_hi      = crc_fcs;
                fcs_hi_ctrl = 4'b0000;
            end
        endcase
    end

    // pad words carry a full mask, everything else uses the decoded input
    always_ff @(posedge i_clk) begin
        crc_data <= (state == PADDING) ? {KEEP_WIDTH{ETH_PAD}} : decoded_data;
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state        <= IDLE;
            adv          <= 1'b1;
            ready_q      <= 1'b0;
            data_pipe    <= {(2*KEEP_WIDTH){XGMII_IDLE}};
            ctrl_pipe    <= '1;
            o_xgmii      <= '{data: {KEEP_WIDTH{XGMII_IDLE}}, ctrl: '1, valid: 1'b1};
            o_frame_done <= '0;
            word_cnt     <= '0;
            ifg_cnt      <= '0;
            term_set     <= 1'b0;
            last_mask    <= '1;
            byte_cnt     <= '0;
            crc_mask     <= '0;
            crc_state    <= CRC_INIT;
        end else begin
            adv           <= !i_xgmii_pause;
            o_xgmii.valid <= adv;
            if (adv) begin
                o_xgmii.data <= data_pipe[XGMII_DATA_WIDTH-1:0];
                o_xgmii.ctrl <= ctrl_pipe[XGMII_CTRL_WIDTH-1:0];
            end

            ready_q             <= 1'b0;
            crc_mask            <= '0;
            crc_state           <= crc_next;
            o_frame_done.strobe <= 1'b0;

            case (state)
                IDLE: begin
                    // the low word leaving now is idle, so both halves can be
                    // replaced with the start word and the rest of the preamble
                    if (adv && i_s_axis_valid) begin
                        data_pipe <= {ETH_SFD, {6{ETH_PREAMBLE}}, XGMII_START};
                        ctrl_pipe <= {{(2*XGMII_CTRL_WIDTH-1){1'b0}}, 1'b1};
                        crc_state <= CRC_INIT;
                        word_cnt  <= '0;
                        byte_cnt  <= '0;
                        ifg_cnt   <= '0;
                        term_set  <= 1'b0;
                        ready_q   <= !i_xgmii_pause;
                        state     <= DATA;
                    end
                end
                DATA: begin
                    ready_q <= !i_xgmii_pause;
                    if (adv) begin
                        data_pipe <= {decoded_data,
                                      data_pipe[2*XGMII_DATA_WIDTH-1 -: XGMII_DATA_WIDTH]};
                        ctrl_pipe <= {{XGMII_CTRL_WIDTH{1'b0}},
                                      ctrl_pipe[2*XGMII_CTRL_WIDTH-1 -: XGMII_CTRL_WIDTH]};
                    end
                    if (xfer) begin
                        crc_mask <= decoded_mask;
                        byte_cnt <= byte_cnt + FRAME_BYTES_WIDTH'(decoded_bytes);
                        if (in_min_region) begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                        if (i_s_axis_word.last) begin
                            ready_q   <= 1'b0;
                            last_mask <= decoded_mask;
                            state     <= (word_cnt < MIN_PAYLOAD_WORDS - 1) ? PADDING : FCS;
                        end
                    end
                end
                PADDING: begin
                    if (adv) begin
                        data_pipe <= {{KEEP_WIDTH{ETH_PAD}},
                                      data_pipe[2*XGMII_DATA_WIDTH-1 -: XGMII_DATA_WIDTH]};
                        ctrl_pipe <= {{XGMII_CTRL_WIDTH{1'b0}},
                                      ctrl_pipe[2*XGMII_CTRL_WIDTH-1 -: XGMII_CTRL_WIDTH]};
                        crc_mask  <= '1;
                        byte_cnt  <= byte_cnt + FRAME_BYTES_WIDTH'(KEEP_WIDTH);
                        word_cnt  <= word_cnt + 1'b1;
                        if (word_cnt == MIN_PAYLOAD_WORDS - 1) begin
                            state <= FCS;
                        end
                    end
                end
                FCS: begin
                    if (adv) begin
                        data_pipe <= {fcs_hi, fcs_lo};
                        ctrl_pipe <= {fcs_hi_ctrl, {XGMII_CTRL_WIDTH{1'b0}}};
                        if (fcs_hi_ctrl != '0) begin
                            term_set                <= 1'b1;
                            o_frame_done.strobe     <= 1'b1;
                            o_frame_done.byte_count <= byte_cnt + FRAME_BYTES_WIDTH'(FCS_BYTES);
                        end
                        state <= IFG;
                    end
                end
                IFG: begin
                    if (adv) begin
                        if (!term_set) begin
                            // full last word, so the terminate opens a word of its own
                            data_pipe <= {{(KEEP_WIDTH-1){XGMII_IDLE}}, XGMII_TERM,
                                          data_pipe[2*XGMII_DATA_WIDTH-1 -: XGMII_DATA_WIDTH]};
                            ctrl_pipe <= {{XGMII_CTRL_WIDTH{1'b1}},
                                          ctrl_pipe[2*XGMII_CTRL_WIDTH-1 -: XGMII_CTRL_WIDTH]};
                            term_set                <= 1'b1;
                            o_frame_done.strobe     <= 1'b1;
                            o_frame_done.byte_count <= byte_cnt + FRAME_BYTES_WIDTH'(FCS_BYTES);
                        end else begin
                            // one extra shift drains the terminate word, the idle
                            // emitted on the next start load completes the gap
                            data_pipe <= {{KEEP_WIDTH{XGMII_IDLE}},
                                          data_pipe[2*XGMII_DATA_WIDTH-1 -: XGMII_DATA_WIDTH]};
                            ctrl_pipe <= {{XGMII_CTRL_WIDTH{1'b1}},
                                          ctrl_pipe[2*XGMII_CTRL_WIDTH-1 -: XGMII_CTRL_WIDTH]};
                            if (ifg_cnt == IFG_IDLE_WORDS) begin
                                state <= IDLE;
                            end else begin
                                ifg_cnt <= ifg_cnt + 1'b1;
                            end
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/tx_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_stats (
    input  wire                               i_clk,
    input  wire                               i_reset_n,
    input  wire eth_tx_pkg::frame_done_t      i_frame_done,
    output logic [eth_tx_pkg::STAT_WIDTH-1:0] o_frame_count,
    output logic [eth_tx_pkg::STAT_WIDTH-1:0] o_byte_count
);
    import eth_tx_pkg::*;

    logic [STAT_WIDTH:0] byte_sum;
    logic                frame_full;

    // one spare bit catches the carry so the byte counter can saturate
    assign byte_sum   = {1'b0, o_byte_count} + (STAT_WIDTH + 1)'(i_frame_done.byte_count);
    assign frame_full = &o_frame_count;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_frame_count <= '0;
            o_byte_count  <= '0;
        end else if (i_frame_done.strobe) begin
            if (!frame_full) begin
                o_frame_count <= o_frame_count + 1'b1;
            end
            if (byte_sum[STAT_WIDTH]) begin
                o_byte_count <= '1;
            end else begin
                o_byte_count <= byte_sum[STAT_WIDTH-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/eth_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_tx_top (
    input  wire                               i_clk,
    input  wire                               i_reset_n,
    input  wire                               i_s_axis_valid,
    input  wire eth_tx_pkg::axis_word_t       i_s_axis_word,
    output logic                              o_s_axis_ready,
    input  wire                               i_xgmii_pause,
    output eth_tx_pkg::xgmii_word_t           o_xgmii,
    output logic [eth_tx_pkg::STAT_WIDTH-1:0] o_frame_count,
    output logic [eth_tx_pkg::STAT_WIDTH-1:0] o_byte_count
);
    import eth_tx_pkg::*;

    // one pulse per frame, raised when the terminate enters the pipeline
    frame_done_t frame_done;

    tx_mac u_tx_mac (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_s_axis_valid (i_s_axis_valid),
        .i_s_axis_word  (i_s_axis_word),
        .o_s_axis_ready (o_s_axis_ready),
        .i_xgmii_pause  (i_xgmii_pause),
        .o_xgmii        (o_xgmii),
        .o_frame_done   (frame_done)
    );

    tx_stats u_tx_stats (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_frame_done  (frame_done),
        .o_frame_count (o_frame_count),
        .o_byte_count  (o_byte_count)
    );

endmodule

`default_nettype wire

/* tb/tb_eth_tx_model.svh */
`ifndef TB_ETH_TX_MODEL_SVH
`define TB_ETH_TX_MODEL_SVH

// xorshift32 step, a zero state would stay zero so the seed is nonzero
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// one byte of the reflected IEEE 802.3 CRC-32, bit 0 of the byte goes first
function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] value);
    logic [31:0] c;
    c = crc ^ {24'h000000, value};
    for (int i = 0; i < 8; i++) begin
        if (c[0]) begin
            c = (c >> 1) ^ 32'hEDB88320;
        end else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

// payload is zero-padded up to the 60 byte minimum
function automatic int padded_length(input int len);
    return (len < 60) ? 60 : len;
endfunction

function automatic logic [7:0] padded_byte(input int len, input int idx);
    return (idx < len) ? frame_buf[idx] : 8'h00;
endfunction

function automatic logic [31:0] frame_fcs(input int len);
    logic [31:0] crc;
    crc = 32'hFFFFFFFF;
    for (int i = 0; i < padded_length(len); i++) begin
        crc = crc32_step(crc, padded_byte(len, i));
    end
    return ~crc;
endfunction

// start, six preamble bytes, SFD, payload, four FCS bytes and the terminate
function automatic int wire_length(input int len);
    return 8 + padded_length(len) + 4 + 1;
endfunction

function automatic logic [7:0] wire_byte(input int len, input int pos, input logic [31:0] fcs);
    int         payload_end;
    logic [7:0] value;
    payload_end = 8 + padded_length(len);
    if (pos == 0) begin
        value = 8'hFB;
    end else if (pos < 7) begin
        value = 8'h55;
    end else if (pos == 7) begin
        value = 8'hD5;
    end else if (pos < payload_end) begin
        value = padded_byte(len, pos - 8);
    end else if (pos < payload_end + 4) begin
        // the FCS leaves lowest byte first
        value = fcs[(pos - payload_end)*8 +: 8];
    end else begin
        value = 8'hFD;
    end
    return value;
endfunction

`endif

/* tb/tb_eth_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_eth_tx;
    import eth_tx_pkg::*;

    localparam int          CLK_PERIOD      = 40;
    localparam logic [31:0] SEED            = 32'h8c1ef972;
    localparam int          MAX_FRAME_BYTES = 256;
    localparam int          FRAMES_PER_RUN  = 12;
    localparam int          WAIT_LIMIT      = 2000;

    logic                  i_clk;
    logic                  i_reset_n;
    logic                  i_s_axis_valid;
    axis_word_t            i_s_axis_word;
    logic                  o_s_axis_ready;
    logic                  i_xgmii_pause;
    xgmii_word_t           o_xgmii;
    logic [STAT_WIDTH-1:0] o_frame_count;
    logic [STAT_WIDTH-1:0] o_byte_count;

    logic [7:0]  frame_buf [0:MAX_FRAME_BYTES-1];
    logic [7:0]  exp_bytes [$];
    logic        exp_ctrl [$];
    logic [31:0] rng_state;
    logic [31:0] bytes_expected;
    logic        pause_d1;
    logic        pause_d2;
    logic        in_frame;
    logic        term_seen;
    int          idle_run;
    int          frame_pos;
    int          frames_sent;
    int          frames_seen;
    int          error_count;

    `include "tb_eth_tx_model.svh"

    eth_tx_top dut (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_s_axis_valid (i_s_axis_valid),
        .i_s_axis_word  (i_s_axis_word),
        .o_s_axis_ready (o_s_axis_ready),
        .i_xgmii_pause  (i_xgmii_pause),
        .o_xgmii        (o_xgmii),
        .o_frame_count  (o_frame_count),
        .o_byte_count   (o_byte_count)
    );

    always #(CLK_PERIOD/2) i_clk = ~i_clk;

    // the valid field must equal the inverse of pause as sampled two edges back
    always @(posedge i_clk) begin
        pause_d1 <= i_xgmii_pause;
        pause_d2 <= pause_d1;
    end

    task automatic check_value(input string name, input logic [31:0] observed,
                               input logic [31:0] expected);
        if (observed !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s observed 0x%0h expected 0x%0h",
                     $time, name, observed, expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic stop_with_failure(input string what);
        error_count++;
        $display("%s (at %0t ns)", what, $time);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic int unsigned random_below(input int unsigned range);
        rng_state = xorshift32(rng_state);
        return rng_state % range;
    endfunction

    // advance to the next falling edge and set the pause level for that cycle
    task automatic step_cycle(input logic pause_on);
        @(negedge i_clk);
        i_xgmii_pause = pause_on ? (random_below(4) == 0) : 1'b0;
    endtask

    task automatic send_frame(input int len, input int gap, input logic pause_on);
        logic [31:0] fcs;
        logic [31:0] word_data;
        logic [3:0]  word_keep;
        logic        taken;
        int          words;
        int          waited;
        for (int i = 0; i < len; i++) begin
            frame_buf[i] = 8'(random_below(256));
        end
        fcs = frame_fcs(len);
        for (int pos = 0; pos < wire_length(len); pos++) begin
            exp_bytes.push_back(wire_byte(len, pos, fcs));
            exp_ctrl.push_back(pos == 0 || pos == wire_length(len) - 1);
        end
        frames_sent++;
        bytes_expected += padded_length(len) + 4;
        words = (len + 3) / 4;
        for (int w = 0; w < words; w++) begin
            for (int lane = 0; lane < 4; lane++) begin
                // lanes past the end carry junk that the keep mask must hide
                word_keep[lane]          = (w*4 + lane < len);
                word_data[lane*8 +: 8]   = word_keep[lane] ? frame_buf[w*4 + lane] : 8'hA5;
            end
            i_s_axis_word.data = word_data;
            i_s_axis_word.keep = word_keep;
            i_s_axis_word.last = (w == words - 1);
            i_s_axis_valid     = 1'b1;
            // ready is registered, so its level now decides the coming rising edge
            taken  = 1'b0;
            waited = 0;
            while (!taken) begin
                taken = o_s_axis_ready;
                step_cycle(pause_on);
                waited++;
                if (!taken && waited > WAIT_LIMIT) begin
                    stop_with_failure("timeout: stream ready never came for a frame word");
                end
            end
        end
        i_s_axis_valid = 1'b0;
        for (int g = 0; g < gap; g++) begin
            step_cycle(pause_on);
        end
    endtask

    // splits XGMII words into frames and idles and checks both
    task automatic capture_word(input logic [31:0] data, input logic [3:0] ctrl);
        logic [7:0] lane_byte;
        logic [7:0] want_byte;
        logic       want_ctrl;
        if (!in_frame && ctrl == 4'hF && data == {4{XGMII_IDLE}}) begin
            idle_run++;
        end
        for (int lane = 0; lane < 4; lane++) begin
            lane_byte = data[lane*8 +: 8];
            if (!in_frame && ctrl[lane] && lane_byte == XGMII_START) begin
                if (term_seen) begin
                    check_value("idle words before start >= 3", idle_run >= IFG_IDLE_WORDS, 1);
                end
                in_frame  = 1'b1;
                frame_pos = 0;
            end
            if (in_frame && exp_bytes.size() == 0) begin
                stop_with_failure("a frame came out on the XGMII output that was never sent");
            end else if (in_frame) begin
                want_byte = exp_bytes.pop_front();
                want_ctrl = exp_ctrl.pop_front();
                check_value($sformatf("o_xgmii.ctrl lane %0d", lane), ctrl[lane], want_ctrl);
                check_value($sformatf("o_xgmii.data lane %0d", lane), lane_byte, want_byte);
                if (want_ctrl && frame_pos > 0) begin
                    in_frame  = 1'b0;
                    term_seen = 1'b1;
                    idle_run  = 0;
                    frames_seen++;
                end
                frame_pos++;
            end else begin
                check_value($sformatf("o_xgmii.ctrl lane %0d", lane), ctrl[lane], 1);
                check_value($sformatf("o_xgmii.data lane %0d", lane), lane_byte, XGMII_IDLE);
            end
        end
    endtask

    initial begin : monitor
        int waited;
        waited = 0;
        while (i_reset_n !== 1'b1) begin
            @(posedge i_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_failure("timeout: reset was never released");
            end
        end
        forever begin
            @(negedge i_clk);
            check_value("o_xgmii.valid", o_xgmii.valid, !pause_d2);
            if (o_xgmii.valid) begin
                capture_word(o_xgmii.data, o_xgmii.ctrl);
            end
        end
    end

    initial begin : stimulus
        int len;
        int gap;
        int waited;
        i_clk          = 1'b0;
        i_reset_n      = 1'b0;
        i_s_axis_valid = 1'b0;
        i_s_axis_word  = '0;
        i_xgmii_pause  = 1'b0;
        rng_state      = SEED;
        bytes_expected = '0;
        in_frame       = 1'b0;
        term_seen      = 1'b0;
        idle_run       = 0;
        frame_pos      = 0;
        frames_sent    = 0;
        frames_seen    = 0;
        error_count    = 0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_reset_n = 1'b1;

        // the line idles and ready stays low while nothing is offered
        for (int i = 0; i < 8; i++) begin
            step_cycle(1'b0);
            check_value("o_s_axis_ready", o_s_axis_ready, 0);
            check_value("o_xgmii.valid", o_xgmii.valid, 1);
            check_value("o_xgmii.ctrl", o_xgmii.ctrl, 4'hF);
            check_value("o_xgmii.data", o_xgmii.data, {4{XGMII_IDLE}});
        end

        // four runs of long frames, short padded frames, random pause and a back-to-back burst
        for (int phase = 0; phase < 4; phase++) begin
            for (int i = 0; i < FRAMES_PER_RUN; i++) begin
                case (phase)
                    0: len = (i < 4) ? 64 + i : 64 + random_below(137);
                    1: len = (i < 4) ? 1 + i : ((i < 8) ? 52 + i : 1 + random_below(59));
                    default: len = 1 + random_below(200);
                endcase
                gap = (phase == 3) ? 0 : random_below(6);
                send_frame(len, gap, phase == 2);
            end
        end

        waited = 0;
        while (frames_seen < frames_sent) begin
            @(posedge i_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_failure("timeout: not every frame sent came out on the XGMII output");
            end
        end
        @(negedge i_clk);
        check_value("expected bytes left over", exp_bytes.size(), 0);
        check_value("o_frame_count", o_frame_count, frames_sent);
        check_value("o_byte_count", o_byte_count, bytes_expected);

        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* eth_tx.f */
+incdir+tb
hw/eth_tx_pkg.sv
hw/crc32.sv
hw/tx_mac.sv
hw/tx_stats.sv
hw/eth_tx_top.sv
tb/tb_eth_tx.sv
